// ==== design/exe_mem_reg.sv ====
`timescale 1ns/1ns
/* one-entry pipeline register, no skid buffer
   in_ready_o depends combinationally on out_ready_i */
module exe_mem_reg (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  lsu_pkg::exe_pkt_t in_pkt_i,
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output lsu_pkg::exe_pkt_t out_pkt_o
);
    import lsu_pkg::*;

    logic     valid_q;
    exe_pkt_t pkt_q;

    assign out_valid_o = valid_q;
    assign out_pkt_o   = pkt_q;

    // empty, or the held packet leaves this cycle
    assign in_ready_o = !valid_q || out_ready_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready_o && in_valid_i) begin
            pkt_q <= in_pkt_i;
        end
    end

    // stalled packet must not change or vanish
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (reset)
        (valid_q && !out_ready_i) |=> (valid_q && $stable(pkt_q))
    ) else $error("exe_mem_reg lost or changed a stalled packet");

endmodule

// ==== design/lsu_backend.sv ====
`timescale 1ns/1ns
/* back end from execute/memory register to writeback packet
   two cycles from input transfer to wb_valid_o, up to two packets in flight */
module lsu_backend (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  lsu_pkg::exe_pkt_t in_pkt_i,
    output logic              wb_valid_o,
    input  logic              wb_ready_i,
    output lsu_pkg::wb_pkt_t  wb_pkt_o
);
    import lsu_pkg::*;

    logic                           stage_valid;
    logic                           stage_ready;
    exe_pkt_t                       stage_pkt;
    bank_req_t [bank_count-1:0]     bank_req;
    logic [bank_count-1:0][7:0]     lane_rdata;

    exe_mem_reg exe_mem_reg_i (
        .clk         (clk),
        .reset       (reset),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_pkt_i    (in_pkt_i),
        .out_valid_o (stage_valid),
        .out_ready_i (stage_ready),
        .out_pkt_o   (stage_pkt)
    );

    mem_req_gen mem_req_gen_i (
        .stage_valid_i (stage_valid),
        .stage_ready_i (stage_ready),
        .stage_pkt_i   (stage_pkt),
        .bank_req_o    (bank_req)
    );

    // one bank per byte lane
    for (genvar i = 0; i < bank_count; i++) begin : g_bank
        mem_bank mem_bank_i (
            .clk     (clk),
            .req_i   (bank_req[i]),
            .rdata_o (lane_rdata[i])
        );
    end

    mem_wb_stage mem_wb_stage_i (
        .clk           (clk),
        .reset         (reset),
        .stage_valid_i (stage_valid),
        .stage_ready_o (stage_ready),
        .stage_pkt_i   (stage_pkt),
        .lane_rdata_i  (lane_rdata),
        .wb_valid_o    (wb_valid_o),
        .wb_ready_i    (wb_ready_i),
        .wb_pkt_o      (wb_pkt_o)
    );

endmodule

// ==== design/lsu_pkg.sv ====
/* shared types for the RV32E load/store back end
   accesses are assumed naturally aligned; memory is 1 KiB in four byte lanes */
package lsu_pkg;

    localparam int xlen_w       = 32;
    localparam int bank_count   = 4;
    localparam int bank_index_w = 8;
    localparam int addr_lsb     = 2;
    localparam int mem_bytes    = 1024;

    // size-coded masks, the request generator shifts them into lanes
    localparam logic [3:0] wmask_byte = 4'b0001;
    localparam logic [3:0] wmask_half = 4'b0011;
    localparam logic [3:0] wmask_word = 4'b1111;

    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_read  = 2'd1,
        mem_write = 2'd2
    } mem_op_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_t;

    typedef struct packed {
        logic      is_unsigned;
        mem_size_t size;
    } rmask_t;

    typedef enum logic [2:0] {
        gpr_sel_alu  = 3'd0,
        gpr_sel_load = 3'd1,
        gpr_sel_csr  = 3'd2,
        gpr_sel_pc4  = 3'd3,
        gpr_sel_imm  = 3'd4
    } gpr_sel_t;

    typedef enum logic [1:0] {
        csr_sel_rs1 = 2'd0,
        csr_sel_alu = 2'd1,
        csr_sel_imm = 2'd2
    } csr_sel_t;

    typedef struct packed {
        logic [xlen_w-1:0] pc;
        logic [xlen_w-1:0] npc;
        logic              redirect;
        logic [xlen_w-1:0] alu_result;
        logic [xlen_w-1:0] sext_imm;
        logic [xlen_w-1:0] rs1_data;
        logic [xlen_w-1:0] rs2_data;
        logic [xlen_w-1:0] csr_rdata;
        logic [3:0]        gpr_waddr;
        logic              gpr_we;
        gpr_sel_t          gpr_sel;
        logic [11:0]       csr_waddr;
        logic              csr_we;
        csr_sel_t          csr_sel;
        logic [3:0]        wmask;
        rmask_t            rmask;
        mem_op_t           mem_op;
        logic              irq;
        logic [7:0]        irq_no;
        logic              is_break;
    } exe_pkt_t;

    typedef struct packed {
        logic                    re;
        logic                    we;
        logic [bank_index_w-1:0] index;
        logic [7:0]              wdata;
    } bank_req_t;

    // one data word seen whole, as halves, or as bytes
    typedef union packed {
        logic [xlen_w-1:0]                word;
        logic [1:0][15:0]                 halves;
        logic [bank_count-1:0][7:0]       bytes;
    } load_word_u;

    typedef struct packed {
        logic [xlen_w-1:0] pc;
        logic [xlen_w-1:0] npc;
        logic              redirect;
        logic              gpr_we;
        logic [3:0]        gpr_waddr;
        logic [xlen_w-1:0] gpr_wdata;
        logic              csr_we;
        logic [11:0]       csr_waddr;
        logic [xlen_w-1:0] csr_wdata;
        logic              irq;
        logic [7:0]        irq_no;
        logic              is_break;
    } wb_pkt_t;

endpackage

// ==== design/mem_bank.sv ====
`timescale 1ns/1ns
/* one byte lane, storage has no reset and powers up unknown
   read byte holds until the next read enable */
module mem_bank (
    input  logic               clk,
    input  lsu_pkg::bank_req_t req_i,
    output logic [7:0]         rdata_o
);
    import lsu_pkg::*;

    logic [7:0] mem_q [mem_bytes/bank_count];

    always_ff @(posedge clk) begin
        if (req_i.we) begin
            mem_q[req_i.index] <= req_i.wdata;
        end
        if (req_i.re) begin
            rdata_o <= mem_q[req_i.index];
        end
    end

endmodule

// ==== design/mem_req_gen.sv ====
`timescale 1ns/1ns
/* per-lane bank requests, enabled only when the stage fires
   misaligned accesses are not trapped, only flagged by an assertion */
module mem_req_gen (
    input  logic                                         stage_valid_i,
    input  logic                                         stage_ready_i,
    input  lsu_pkg::exe_pkt_t                            stage_pkt_i,
    output lsu_pkg::bank_req_t [lsu_pkg::bank_count-1:0] bank_req_o
);
    import lsu_pkg::*;

    logic                    fire;
    logic [addr_lsb-1:0]     offset;
    logic [bank_index_w-1:0] index;
    logic [bank_count-1:0]   lane_we;
    load_word_u              store_word;
    logic                    aligned;

    assign fire    = stage_valid_i && stage_ready_i;
    assign offset  = stage_pkt_i.alu_result[addr_lsb-1:0];
    assign index   = stage_pkt_i.alu_result[addr_lsb +: bank_index_w];
    assign lane_we = stage_pkt_i.wmask << offset;

    // store data moves into the same lanes as the mask
    always_comb begin
        store_word.word = stage_pkt_i.rs2_data << {offset, 3'b000};
    end

    always_comb begin
        for (int i = 0; i < bank_count; i++) begin
            bank_req_o[i].re    = fire && (stage_pkt_i.mem_op == mem_read);
            bank_req_o[i].we    = fire && (stage_pkt_i.mem_op == mem_write) && lane_we[i];
            bank_req_o[i].index = index;
            bank_req_o[i].wdata = store_word.bytes[i];
        end
    end

    always_comb begin
        aligned = 1'b1;
        if (stage_pkt_i.mem_op == mem_read) begin
            case (stage_pkt_i.rmask.size)
                size_half: aligned = !offset[0];
                size_word: aligned = (offset == '0);
                default:   aligned = 1'b1;
            endcase
        end else if (stage_pkt_i.mem_op == mem_write) begin
            case (stage_pkt_i.wmask)
                wmask_byte: aligned = 1'b1;
                wmask_half: aligned = !offset[0];
                wmask_word: aligned = (offset == '0);
                default:    aligned = 1'b0;
            endcase
        end
    end

    // no clock here, so checked at the end of the time step
    always_comb begin
        if (fire) begin
            a_aligned: assert final (aligned)
                else $error("misaligned access at %h", stage_pkt_i.alu_result);
        end
    end

endmodule

// ==== design/mem_wb_stage.sv ====
`timescale 1ns/1ns
/* result register for the writeback packet, load data is muxed in from the banks
   banks must hold their read bytes while the result is stalled */
module mem_wb_stage (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   stage_valid_i,
    output logic                                   stage_ready_o,
    input  lsu_pkg::exe_pkt_t                      stage_pkt_i,
    input  logic [lsu_pkg::bank_count-1:0][7:0]    lane_rdata_i,
    output logic                                   wb_valid_o,
    input  logic                                   wb_ready_i,
    output lsu_pkg::wb_pkt_t                       wb_pkt_o
);
    import lsu_pkg::*;

    typedef struct packed {
        logic                is_load;
        logic [addr_lsb-1:0] offset;
        rmask_t              rmask;
    } load_info_t;

    logic              fire;
    logic [xlen_w-1:0] pc_plus4;
    wb_pkt_t           res_d;
    wb_pkt_t           res_q;
    load_info_t        ld_q;
    load_word_u        lane_word;
    logic [7:0]        sel_byte;
    logic [15:0]       sel_half;
    logic              fill;
    logic [xlen_w-1:0] load_data;

    assign stage_ready_o = !wb_valid_o || wb_ready_i;
    assign fire          = stage_valid_i && stage_ready_o;
    assign pc_plus4      = stage_pkt_i.pc + 32'd4;

    // everything but the load value is settled before the result register
    always_comb begin
        res_d.pc        = stage_pkt_i.pc;
        res_d.npc       = stage_pkt_i.npc;
        res_d.redirect  = stage_pkt_i.redirect;
        res_d.gpr_we    = stage_pkt_i.gpr_we;
        res_d.gpr_waddr = stage_pkt_i.gpr_waddr;
        res_d.csr_we    = stage_pkt_i.csr_we;
        res_d.csr_waddr = stage_pkt_i.csr_waddr;
        res_d.irq       = stage_pkt_i.irq;
        res_d.irq_no    = stage_pkt_i.irq_no;
        res_d.is_break  = stage_pkt_i.is_break;
        case (stage_pkt_i.gpr_sel)
            gpr_sel_csr: res_d.gpr_wdata = stage_pkt_i.csr_rdata;
            gpr_sel_pc4: res_d.gpr_wdata = pc_plus4;
            gpr_sel_imm: res_d.gpr_wdata = stage_pkt_i.sext_imm;
            // load value replaced at the output
            default:     res_d.gpr_wdata = stage_pkt_i.alu_result;
        endcase
        case (stage_pkt_i.csr_sel)
            csr_sel_alu: res_d.csr_wdata = stage_pkt_i.alu_result;
            csr_sel_imm: res_d.csr_wdata = stage_pkt_i.sext_imm;
            default:     res_d.csr_wdata = stage_pkt_i.rs1_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid_o <= 1'b0;
        end else if (stage_ready_o) begin
            wb_valid_o <= stage_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            res_q         <= res_d;
            ld_q.is_load  <= (stage_pkt_i.gpr_sel == gpr_sel_load);
            ld_q.offset   <= stage_pkt_i.alu_result[addr_lsb-1:0];
            ld_q.rmask    <= stage_pkt_i.rmask;
        end
    end

    // bank bytes arrive the cycle after fire
    always_comb begin
        lane_word.bytes = lane_rdata_i;
        sel_byte        = lane_word.bytes[ld_q.offset];
        sel_half        = lane_word.halves[ld_q.offset[1]];
        case (ld_q.rmask.size)
            size_byte: begin
                fill      = !ld_q.rmask.is_unsigned && sel_byte[7];
                load_data = {{(xlen_w-8){fill}}, sel_byte};
            end
            size_half: begin
                fill      = !ld_q.rmask.is_unsigned && sel_half[15];
                load_data = {{(xlen_w-16){fill}}, sel_half};
            end
            default: begin
                fill      = 1'b0;
                load_data = lane_word.word;
            end
        endcase
    end

    always_comb begin
        wb_pkt_o = res_q;
        if (ld_q.is_load) begin
            wb_pkt_o.gpr_wdata = load_data;
        end
    end

    a_valid_known: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(wb_valid_o)
    ) else $error("wb_valid_o is unknown");

endmodule

// ==== sim.f ====
+incdir+tests
design/lsu_pkg.sv
design/exe_mem_reg.sv
design/mem_req_gen.sv
design/mem_bank.sv
design/mem_wb_stage.sv
design/lsu_backend.sv
tests/tb_lsu_backend.sv

// ==== tests/lsu_checks.svh ====
/* byte-level memory model and compare tasks, included inside the testbench module
   model assumes aligned accesses and loads only of bytes written earlier */
`ifndef lsu_checks_svh
`define lsu_checks_svh

logic [7:0] ref_mem [mem_bytes];

function automatic logic [xlen_w-1:0] model_load(input logic [xlen_w-1:0] addr,
                                                 input rmask_t rm);
    load_word_u  w;
    logic [7:0]  b;
    logic [15:0] h;
    for (int i = 0; i < bank_count; i++) begin
        w.bytes[i] = ref_mem[{addr[9:2], 2'(i)}];
    end
    b = w.bytes[addr[1:0]];
    h = w.halves[addr[1]];
    case (rm.size)
        size_byte: return rm.is_unsigned ? {24'h0, b} : {{24{b[7]}}, b};
        size_half: return rm.is_unsigned ? {16'h0, h} : {{16{h[15]}}, h};
        default:   return w.word;
    endcase
endfunction

// expected writeback, also applies a store to the model
function automatic wb_pkt_t predict_wb(input exe_pkt_t p);
    wb_pkt_t e;
    e.pc        = p.pc;
    e.npc       = p.npc;
    e.redirect  = p.redirect;
    e.gpr_we    = p.gpr_we;
    e.gpr_waddr = p.gpr_waddr;
    e.csr_we    = p.csr_we;
    e.csr_waddr = p.csr_waddr;
    e.irq       = p.irq;
    e.irq_no    = p.irq_no;
    e.is_break  = p.is_break;
    case (p.gpr_sel)
        gpr_sel_load: e.gpr_wdata = model_load(p.alu_result, p.rmask);
        gpr_sel_csr:  e.gpr_wdata = p.csr_rdata;
        gpr_sel_pc4:  e.gpr_wdata = p.pc + 4;
        gpr_sel_imm:  e.gpr_wdata = p.sext_imm;
        default:      e.gpr_wdata = p.alu_result;
    endcase
    case (p.csr_sel)
        csr_sel_alu: e.csr_wdata = p.alu_result;
        csr_sel_imm: e.csr_wdata = p.sext_imm;
        default:     e.csr_wdata = p.rs1_data;
    endcase
    if (p.mem_op == mem_write) begin
        for (int i = 0; i < bank_count; i++) begin
            if (p.wmask[i]) begin
                ref_mem[10'(p.alu_result[9:0] + i)] = p.rs2_data[8*i +: 8];
            end
        end
    end
    return e;
endfunction

task automatic compare_word(input string field, input load_word_u exp, input load_word_u act);
    if (act.word !== exp.word) begin
        fail_run($sformatf("** Error %s expected %h actual %h", field, exp.word, act.word));
    end
endtask

task automatic compare_wb_pkt(input wb_pkt_t exp, input wb_pkt_t act);
    compare_word("wb_pkt_o.pc", exp.pc, act.pc);
    compare_word("wb_pkt_o.npc", exp.npc, act.npc);
    compare_word("wb_pkt_o.redirect", exp.redirect, act.redirect);
    compare_word("wb_pkt_o.gpr_we", exp.gpr_we, act.gpr_we);
    compare_word("wb_pkt_o.gpr_waddr", exp.gpr_waddr, act.gpr_waddr);
    compare_word("wb_pkt_o.gpr_wdata", exp.gpr_wdata, act.gpr_wdata);
    compare_word("wb_pkt_o.csr_we", exp.csr_we, act.csr_we);
    compare_word("wb_pkt_o.csr_waddr", exp.csr_waddr, act.csr_waddr);
    compare_word("wb_pkt_o.csr_wdata", exp.csr_wdata, act.csr_wdata);
    compare_word("wb_pkt_o.irq", exp.irq, act.irq);
    compare_word("wb_pkt_o.irq_no", exp.irq_no, act.irq_no);
    compare_word("wb_pkt_o.is_break", exp.is_break, act.is_break);
endtask

`endif

// ==== tests/tb_lsu_backend.sv ====
`timescale 1ns/1ns
/* directed tests for lsu_backend against a byte-level memory model
   words 0 to 7 are written by the word stores before any later test loads them */
module tb_lsu_backend;
    import lsu_pkg::*;

    localparam int clk_period   = 20;
    localparam int reset_cycles = 10;
    localparam int word_pkts    = 20;
    localparam int subword_pkts = 32;
    localparam int select_pkts  = 20;
    localparam int burst_pkts   = 20;
    localparam int planned_pkts = word_pkts + subword_pkts + select_pkts + burst_pkts;
    localparam gpr_sel_t nonload_sel [4] = '{gpr_sel_alu, gpr_sel_csr, gpr_sel_pc4, gpr_sel_imm};

    logic     clk;
    logic     reset;
    logic     in_valid;
    logic     in_ready;
    exe_pkt_t in_pkt;
    logic     wb_valid;
    logic     wb_ready;
    wb_pkt_t  wb_pkt;
    wb_pkt_t  exp_q [$];
    int       in_edge_q [$];
    int       edge_count    = 0;
    int       sent_count    = 0;
    int       out_count     = 0;
    logic     check_latency = 1'b1;
    logic     held_valid    = 1'b0;
    wb_pkt_t  held_pkt;

    `include "lsu_checks.svh"

    lsu_backend lsu_backend_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid_i (in_valid),
        .in_ready_o (in_ready),
        .in_pkt_i   (in_pkt),
        .wb_valid_o (wb_valid),
        .wb_ready_i (wb_ready),
        .wb_pkt_o   (wb_pkt)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    // generous budget per packet
    initial begin
        #((reset_cycles + 50 * planned_pkts) * clk_period);
        fail_run("run timed out waiting for the DUT");
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic exe_pkt_t base_pkt();
        logic [$bits(exe_pkt_t)-1:0] bits;
        exe_pkt_t                    p;
        for (int i = 0; i < $bits(exe_pkt_t); i++) begin
            bits[i] = 1'($urandom_range(0, 1));
        end
        p            = bits;
        p.pc[1:0]    = 2'b00;
        p.gpr_sel    = nonload_sel[$urandom_range(0, 3)];
        p.csr_sel    = csr_sel_t'($urandom_range(0, 2));
        p.rmask.size = mem_size_t'($urandom_range(0, 2));
        p.mem_op     = mem_none;
        return p;
    endfunction

    function automatic exe_pkt_t mem_pkt(input mem_op_t op, input logic [xlen_w-1:0] addr,
                                         input mem_size_t size, input logic uns,
                                         input logic [xlen_w-1:0] wdata);
        exe_pkt_t p;
        p                   = base_pkt();
        p.mem_op            = op;
        p.alu_result        = addr;
        p.rs2_data          = wdata;
        p.rmask.size        = size;
        p.rmask.is_unsigned = uns;
        p.wmask = (size == size_byte) ? wmask_byte : (size == size_half) ? wmask_half : wmask_word;
        if (op == mem_read) begin
            p.gpr_sel = gpr_sel_load;
            p.gpr_we  = 1'b1;
        end
        return p;
    endfunction

    // aligned access somewhere in words 0 to 7
    function automatic exe_pkt_t random_pkt();
        mem_size_t         size;
        logic [xlen_w-1:0] addr;
        size = mem_size_t'($urandom_range(0, 2));
        addr = 32'(4 * $urandom_range(0, 7));
        if (size == size_byte) begin
            addr += $urandom_range(0, 3);
        end else if (size == size_half) begin
            addr += 2 * $urandom_range(0, 1);
        end
        case ($urandom_range(0, 2))
            0:       return base_pkt();
            1:       return mem_pkt(mem_read, addr, size, 1'($urandom_range(0, 1)), '0);
            default: return mem_pkt(mem_write, addr, size, 1'b0, $urandom);
        endcase
    endfunction

    task automatic send(input exe_pkt_t p);
        in_valid <= 1'b1;
        in_pkt   <= p;
        do begin
            @(negedge clk);
        end while (in_ready !== 1'b1);
        exp_q.push_back(predict_wb(p));
        in_edge_q.push_back(edge_count);
        sent_count++;
        @(posedge clk);
    endtask

    task automatic drain();
        in_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
    endtask

    always @(negedge clk) begin : monitor
        wb_pkt_t exp;
        int      in_edge;
        if (!reset) begin
            // stalled result must hold still
            if (held_valid) begin
                if (wb_valid !== 1'b1) begin
                    fail_run("wb_valid_o dropped while wb_ready_i was low");
                end
                compare_wb_pkt(held_pkt, wb_pkt);
            end
            if (wb_valid && wb_ready) begin
                if (exp_q.size() == 0) begin
                    fail_run("writeback packet came out with no matching input");
                end
                exp     = exp_q.pop_front();
                in_edge = in_edge_q.pop_front();
                compare_wb_pkt(exp, wb_pkt);
                if (check_latency && (edge_count - in_edge != 2)) begin
                    fail_run($sformatf("output came %0d cycles after its input instead of 2",
                                       edge_count - in_edge));
                end
                out_count++;
            end
            held_valid = wb_valid && !wb_ready;
            held_pkt   = wb_pkt;
        end
    end

    task automatic idle_after_reset();
        repeat (5) begin
            @(negedge clk);
            compare_word("wb_valid_o", 1'b0, wb_valid);
            compare_word("in_ready_o", 1'b1, in_ready);
        end
        @(posedge clk);
    endtask

    task automatic word_store_load();
        logic [xlen_w-1:0] word_addrs [10] = '{32'h000, 32'h004, 32'h008, 32'h00c, 32'h010,
                                               32'h014, 32'h018, 32'h01c, 32'h3f8, 32'h3fc};
        foreach (word_addrs[i]) begin
            send(mem_pkt(mem_write, word_addrs[i], size_word, 1'b0, $urandom));
        end
        foreach (word_addrs[i]) begin
            send(mem_pkt(mem_read, word_addrs[i], size_word, 1'b0, '0));
        end
        drain();
    endtask

    task automatic subword_store_load();
        for (int off = 0; off < 4; off++) begin
            send(mem_pkt(mem_write, 32'h40 + off, size_byte, 1'b0, $urandom));
        end
        for (int off = 0; off < 4; off += 2) begin
            send(mem_pkt(mem_write, 32'h44 + off, size_half, 1'b0, $urandom));
        end
        for (int w = 0; w < 2; w++) begin
            for (int off = 0; off < 4; off++) begin
                for (int u = 0; u < 2; u++) begin
                    send(mem_pkt(mem_read, 32'h40 + 4 * w + off, size_byte, u[0], '0));
                    if (!off[0]) begin
                        send(mem_pkt(mem_read, 32'h40 + 4 * w + off, size_half, u[0], '0));
                    end
                end
            end
            send(mem_pkt(mem_read, 32'h40 + 4 * w, size_word, 1'b0, '0));
        end
        drain();
    endtask

    task automatic select_passthrough();
        exe_pkt_t p;
        for (int g = 0; g < 4; g++) begin
            for (int c = 0; c < 3; c++) begin
                p            = base_pkt();
                p.gpr_sel    = nonload_sel[g];
                p.csr_sel    = csr_sel_t'(c);
                p.wmask      = wmask_word;
                p.alu_result = 32'(4 * $urandom_range(0, 7));
                send(p);
            end
        end
        // words 0 to 7 must be untouched
        for (int i = 0; i < 8; i++) begin
            send(mem_pkt(mem_read, 32'(4 * i), size_word, 1'b0, '0));
        end
        drain();
    endtask

    task automatic random_burst();
        logic done;
        check_latency = 1'b0;
        done          = 1'b0;
        fork
            begin
                repeat (burst_pkts) begin
                    send(random_pkt());
                end
                in_valid <= 1'b0;
                done = 1'b1;
            end
            begin
                while (!done) begin
                    wb_ready <= 1'b0;
                    repeat ($urandom_range(1, 4)) @(posedge clk);
                    wb_ready <= 1'b1;
                    repeat ($urandom_range(1, 3)) @(posedge clk);
                end
            end
        join
        drain();
    endtask

    initial begin
        void'($urandom(50));
        reset    <= 1'b1;
        in_valid <= 1'b0;
        in_pkt   <= '0;
        wb_ready <= 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        idle_after_reset();
        word_store_load();
        subword_store_load();
        select_passthrough();
        random_burst();
        $display("Regression passed");
        $finish;
    end

endmodule
